/* logic/isaPkg.sv */
package isaPkg;

   ///////////////////////////////////////////////////////////////////////////
   // Basic machine types
   ///////////////////////////////////////////////////////////////////////////
   typedef logic [15:0] wordT;             // Data, address or instruction word
   typedef logic [2:0]  regIdxT;           // One of eight registers

   // Legal opcodes, bits 15..11
   typedef enum logic [4:0] {
      OpHalt = 5'b00000,                   // Stop the core
      OpNop  = 5'b00001,                   // No operation
      OpJ    = 5'b00100,                   // PC+2 + Disp11
      OpAddi = 5'b01000,                   // Rt = Rs + Imm5
      OpSubi = 5'b01001,                   // Rt = Imm5 - Rs
      OpBeqz = 5'b01100,                   // Taken if Rs == 0
      OpBnez = 5'b01101,                   // Taken if Rs != 0
      OpSt   = 5'b10000,                   // Mem[Rs + Imm5] = Rt
      OpLd   = 5'b10001,                   // Rt = Mem[Rs + Imm5]
      OpLbi  = 5'b11000,                   // Rs = Imm8
      OpAlu  = 5'b11011                    // Rd = Rs op Rt
   } opcodeE;

   // Register-form function select, bits 1..0
   typedef enum logic [1:0] {
      FnAdd = 2'b00,                       // Rs + Rt
      FnSub = 2'b01,                       // Rt - Rs
      FnXor = 2'b10,
      FnAnd = 2'b11
   } aluFuncE;

   ///////////////////////////////////////////////////////////////////////////
   // Instruction field positions
   ///////////////////////////////////////////////////////////////////////////
   localparam int OpcodeMsb = 15;
   localparam int OpcodeLsb = 11;
   localparam int RsMsb     = 10;
   localparam int RsLsb     = 8;
   localparam int RtMsb     = 7;
   localparam int RtLsb     = 5;
   localparam int RdMsb     = 4;          // Register form only
   localparam int RdLsb     = 2;
   localparam int FuncMsb   = 1;
   localparam int FuncLsb   = 0;
   localparam int Imm5Msb   = 4;          // Doubles as sign bit
   localparam int Imm8Msb   = 7;
   localparam int Disp11Msb = 10;
   localparam int ImmLsb    = 0;          // All immediates start at bit 0

endpackage

/* logic/ctrlPkg.sv */
package ctrlPkg;

   // One instruction walks through these in order
   typedef enum logic [2:0] {
      Fetch     = 3'd0,                    // Read instruction memory
      Decode    = 3'd1,                    // Fields, regs, control
      Execute   = 3'd2,                    // ALU and branch decision
      Memory    = 3'd3,                    // Data memory access
      Writeback = 3'd4,                    // Register file write
      Halted    = 3'd5,                    // Terminal after HALT
      Error     = 3'd6                     // Terminal after bad opcode
   } stageE;

   // Operation carried out by the execute unit
   typedef enum logic [3:0] {
      Add      = 4'd0,                     // Rs + operand B
      SubRev   = 4'd1,                     // Operand B - Rs
      Xor      = 4'd2,
      And      = 4'd3,
      PassImm  = 4'd4,                     // LBI
      AddrCalc = 4'd5,                     // Rs + Imm5 for LD/ST
      BranchZ  = 4'd6,
      BranchNz = 4'd7,
      Jump     = 4'd8,                     // Always taken
      None     = 4'd9
   } exOpE;

endpackage

/* logic/stageSequencer.sv */
module stageSequencer (
   input  logic           clk,
   input  logic           rstN,
   input  logic           isHalt,          // Decoded HALT, valid in Decode
   input  logic           isIllegal,       // Unknown opcode, valid in Decode
   output ctrlPkg::stageE stage,
   output logic           halted,
   output logic           err
);
   import ctrlPkg::*;

   stageE nextStage;                       // Next-state value

   ///////////////////////////////////////////////////////////////////////////
   // State register
   ///////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rstN) begin
         stage <= Fetch;                   // Start with a fetch
      end else begin
         stage <= nextStage;
      end
   end

   ///////////////////////////////////////////////////////////////////////////
   // Next-state logic
   ///////////////////////////////////////////////////////////////////////////
   always_comb begin
      nextStage = stage;                   // Terminal states hold
      case (stage)
         Fetch: begin
            nextStage = Decode;
         end
         Decode: begin
            if (isHalt) begin
               nextStage = Halted;         // HALT wins over illegal
            end else if (isIllegal) begin
               nextStage = Error;
            end else begin
               nextStage = Execute;
            end
         end
         Execute: begin
            nextStage = Memory;
         end
         Memory: begin
            nextStage = Writeback;
         end
         Writeback: begin
            nextStage = Fetch;             // Next instruction
         end
         Halted: begin
            nextStage = Halted;
         end
         Error: begin
            nextStage = Error;
         end
         default: begin
            nextStage = Error;             // Unused encoding 7
         end
      endcase
   end

   // Status straight from the state
   assign halted = (stage == Halted);
   assign err    = (stage == Error);

endmodule

/* logic/pcCounter.sv */
module pcCounter #(
   parameter isaPkg::wordT ResetPc = 16'h0000  // Must be even
) (
   input  logic           clk,
   input  logic           rstN,
   input  ctrlPkg::stageE stage,
   input  logic           takeJump,        // Branch taken or J
   input  isaPkg::wordT   jumpTarget,      // PC+2 + offset
   output isaPkg::wordT   pc
);
   import ctrlPkg::*;

   localparam isaPkg::wordT PcStep = 16'd2; // One instruction word

   // Program counter
   // From Decode on, pc already holds PC+2 of the current instruction
   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= ResetPc;
      end else if (stage == Fetch) begin
         pc <= pc + PcStep;                // Wraps at 64K
      end else if ((stage == Execute) && takeJump) begin
         pc <= jumpTarget;                 // Taken branch or jump
      end
   end

endmodule

/* logic/instrDecoder.sv */
module instrDecoder (
   input  logic            clk,
   input  logic            rstN,
   input  ctrlPkg::stageE  stage,
   input  isaPkg::wordT    instr,          // From instruction memory
   output isaPkg::regIdxT  rsIdx,
   output isaPkg::regIdxT  rtIdx,
   output isaPkg::regIdxT  wrIdx,          // Destination register
   output isaPkg::wordT    imm,            // Sign extended
   output ctrlPkg::exOpE   exOp,
   output logic            useImm,         // Operand B is imm
   output logic            regWrite,
   output logic            memRead,        // LD, Memory stage only
   output logic            memWrite,       // ST, Memory stage only
   output logic            isHalt,
   output logic            isIllegal
);
   import isaPkg::*;
   import ctrlPkg::*;

   localparam wordT NopWord = {OpNop, 11'b0}; // Harmless value after reset

   wordT    instrQ;                        // Latched instruction
   opcodeE  opcode;
   aluFuncE func;
   wordT    imm5Se;
   wordT    imm8Se;
   wordT    disp11Se;
   logic    isLd;
   logic    isSt;

   // Instruction register, loaded at end of Fetch
   always_ff @(posedge clk) begin
      if (!rstN) begin
         instrQ <= NopWord;
      end else if (stage == Fetch) begin
         instrQ <= instr;
      end
   end

   ///////////////////////////////////////////////////////////////////////////
   // Field extraction
   ///////////////////////////////////////////////////////////////////////////
   assign opcode   = opcodeE'(instrQ[OpcodeMsb:OpcodeLsb]);
   assign func     = aluFuncE'(instrQ[FuncMsb:FuncLsb]);
   assign rsIdx    = instrQ[RsMsb:RsLsb];
   assign rtIdx    = instrQ[RtMsb:RtLsb];
   assign imm5Se   = {{11{instrQ[Imm5Msb]}}, instrQ[Imm5Msb:ImmLsb]};
   assign imm8Se   = {{8{instrQ[Imm8Msb]}}, instrQ[Imm8Msb:ImmLsb]};
   assign disp11Se = {{5{instrQ[Disp11Msb]}}, instrQ[Disp11Msb:ImmLsb]};

   ///////////////////////////////////////////////////////////////////////////
   // Control decode
   ///////////////////////////////////////////////////////////////////////////
   always_comb begin
      wrIdx     = instrQ[RtMsb:RtLsb];     // I-form default
      imm       = '0;
      exOp      = None;
      useImm    = 1'b0;
      regWrite  = 1'b0;
      isLd      = 1'b0;
      isSt      = 1'b0;
      isHalt    = 1'b0;
      isIllegal = 1'b0;
      case (opcode)
         OpHalt: isHalt = 1'b1;
         OpNop:  exOp = None;              // Walks all stages, no effect
         OpAddi, OpSubi: begin
            exOp     = (opcode == OpAddi) ? Add : SubRev;
            imm      = imm5Se;
            useImm   = 1'b1;
            regWrite = 1'b1;
         end
         OpLbi: begin
            wrIdx    = instrQ[RsMsb:RsLsb]; // LBI writes Rs
            exOp     = PassImm;
            imm      = imm8Se;
            useImm   = 1'b1;
            regWrite = 1'b1;
         end
         OpAlu: begin
            wrIdx    = instrQ[RdMsb:RdLsb];
            regWrite = 1'b1;
            case (func)
               FnAdd: exOp = Add;
               FnSub: exOp = SubRev;       // Rt - Rs
               FnXor: exOp = Xor;
               FnAnd: exOp = And;
            endcase
         end
         OpSt, OpLd: begin
            exOp     = AddrCalc;
            imm      = imm5Se;
            useImm   = 1'b1;
            regWrite = (opcode == OpLd);
            isLd     = (opcode == OpLd);
            isSt     = (opcode == OpSt);
         end
         OpBeqz: begin
            exOp = BranchZ;
            imm  = imm8Se;
         end
         OpBnez: begin
            exOp = BranchNz;
            imm  = imm8Se;
         end
         OpJ: begin
            exOp = Jump;
            imm  = disp11Se;
         end
         default: isIllegal = 1'b1;        // Outside opcodeE
      endcase
   end

   // One-cycle memory strobes
   assign memRead  = isLd & (stage == Memory);
   assign memWrite = isSt & (stage == Memory);

endmodule

/* logic/regFile.sv */
module regFile (
   input  logic           clk,
   input  logic           rstN,
   input  ctrlPkg::stageE stage,
   input  isaPkg::regIdxT rsIdx,
   input  isaPkg::regIdxT rtIdx,
   input  isaPkg::regIdxT wrIdx,
   input  logic           regWrite,
   input  isaPkg::wordT   wrData,          // Result register
   output isaPkg::wordT   rsData,
   output isaPkg::wordT   rtData
);
   import isaPkg::*;
   import ctrlPkg::*;

   localparam int NumRegs = 8;

   wordT regs [NumRegs];                   // R0..R7, R0 is a normal register

   // Write port, Writeback only
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if ((stage == Writeback) && regWrite) begin
         regs[wrIdx] <= wrData;
      end
   end

   // Read ports, combinational
   assign rsData = regs[rsIdx];
   assign rtData = regs[rtIdx];

endmodule

/* logic/execUnit.sv */
module execUnit (
   input  logic           clk,
   input  logic           rstN,
   input  ctrlPkg::stageE stage,
   input  ctrlPkg::exOpE  exOp,
   input  logic           useImm,          // Select imm as operand B
   input  logic           memRead,         // LD in Memory stage
   input  isaPkg::wordT   rsData,
   input  isaPkg::wordT   rtData,
   input  isaPkg::wordT   imm,
   input  isaPkg::wordT   pc,              // Already PC+2
   input  isaPkg::wordT   memRdata,
   output isaPkg::wordT   result,          // ALU result or load data
   output isaPkg::wordT   jumpTarget,
   output logic           takeJump
);
   import isaPkg::*;
   import ctrlPkg::*;

   wordT opB;                              // Second ALU operand
   wordT aluOut;
   logic rsZero;

   assign opB    = useImm ? imm : rtData;
   assign rsZero = (rsData == '0);

   ///////////////////////////////////////////////////////////////////////////
   // ALU
   ///////////////////////////////////////////////////////////////////////////
   always_comb begin
      case (exOp)
         Add, AddrCalc: aluOut = rsData + opB; // Wraps mod 2^16
         SubRev:        aluOut = opB - rsData;
         Xor:           aluOut = rsData ^ opB;
         And:           aluOut = rsData & opB;
         PassImm:       aluOut = imm;      // LBI
         default:       aluOut = '0;       // Branches, jump, NOP
      endcase
   end

   ///////////////////////////////////////////////////////////////////////////
   // Branch decision and target
   ///////////////////////////////////////////////////////////////////////////
   always_comb begin
      case (exOp)
         BranchZ:  takeJump = rsZero;
         BranchNz: takeJump = !rsZero;
         Jump:     takeJump = 1'b1;
         default:  takeJump = 1'b0;
      endcase
   end

   assign jumpTarget = pc + imm;           // Relative to PC+2

   // Result register
   // ALU output at end of Execute, replaced by load data at end of Memory
   always_ff @(posedge clk) begin
      if (!rstN) begin
         result <= '0;
      end else if (stage == Execute) begin
         result <= aluOut;
      end else if (memRead) begin
         result <= memRdata;               // Writeback always uses result
      end
   end

endmodule

/* logic/proc.sv */
module proc #(
   parameter isaPkg::wordT ResetPc = 16'h0000  // Reset vector, even
) (
   input  logic         clk,
   input  logic         rstN,
   input  isaPkg::wordT instr,             // Instruction memory data
   input  isaPkg::wordT memRdata,          // Data memory read data
   output isaPkg::wordT instrAddr,
   output isaPkg::wordT memAddr,
   output isaPkg::wordT memWdata,
   output logic         memWe,             // One cycle per ST
   output logic         memRe,             // One cycle per LD
   output logic         halted,
   output logic         err
);
   import isaPkg::*;
   import ctrlPkg::*;

   ///////////////////////////////////////////////////////////////////////////
   // Internal nets
   ///////////////////////////////////////////////////////////////////////////
   stageE  stage;
   wordT   pc;
   regIdxT rsIdx;
   regIdxT rtIdx;
   regIdxT wrIdx;
   wordT   imm;
   exOpE   exOp;
   logic   useImm;
   logic   regWrite;
   logic   memRead;                        // Already qualified by Memory
   logic   memWrite;
   logic   isHalt;
   logic   isIllegal;
   wordT   rsData;
   wordT   rtData;
   wordT   result;
   wordT   jumpTarget;
   logic   takeJump;

   stageSequencer iStageSeq (
      .clk(clk), .rstN(rstN),
      .isHalt(isHalt), .isIllegal(isIllegal),
      .stage(stage), .halted(halted), .err(err)
   );

   pcCounter #(.ResetPc(ResetPc)) iPcCounter (
      .clk(clk), .rstN(rstN), .stage(stage),
      .takeJump(takeJump), .jumpTarget(jumpTarget),
      .pc(pc)
   );

   instrDecoder iDecoder (
      .clk(clk), .rstN(rstN), .stage(stage), .instr(instr),
      .rsIdx(rsIdx), .rtIdx(rtIdx), .wrIdx(wrIdx), .imm(imm),
      .exOp(exOp), .useImm(useImm), .regWrite(regWrite),
      .memRead(memRead), .memWrite(memWrite),
      .isHalt(isHalt), .isIllegal(isIllegal)
   );

   regFile iRegFile (
      .clk(clk), .rstN(rstN), .stage(stage),
      .rsIdx(rsIdx), .rtIdx(rtIdx), .wrIdx(wrIdx),
      .regWrite(regWrite), .wrData(result),
      .rsData(rsData), .rtData(rtData)
   );

   execUnit iExecUnit (
      .clk(clk), .rstN(rstN), .stage(stage),
      .exOp(exOp), .useImm(useImm), .memRead(memRead),
      .rsData(rsData), .rtData(rtData), .imm(imm), .pc(pc),
      .memRdata(memRdata),
      .result(result), .jumpTarget(jumpTarget), .takeJump(takeJump)
   );

   // External buses
   assign instrAddr = pc;
   assign memAddr   = result;              // Address computed in Execute
   assign memWdata  = rtData;              // Store data is Rt
   assign memWe     = memWrite;
   assign memRe     = memRead;

endmodule

/* verif/proc_assert.sv */
module procAssert (
   input logic         clk,
   input logic         rstN,
   input logic         memWe,
   input logic         memRe,
   input logic         halted,
   input logic         err,
   input isaPkg::wordT instrAddr
);
   timeunit 1ns;
   timeprecision 100ps;

   // Data bus strobes
   weReExclusive: assert property (@(posedge clk) disable iff (!rstN) !(memWe && memRe))
      else $error("memWe and memRe high in the same cycle");
   weSingle: assert property (@(posedge clk) disable iff (!rstN) memWe |=> !memWe)
      else $error("memWe high for more than one cycle");
   reSingle: assert property (@(posedge clk) disable iff (!rstN) memRe |=> !memRe)
      else $error("memRe high for more than one cycle");

   // Terminal status is sticky until reset
   haltedSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
      else $error("halted dropped without reset");
   errSticky: assert property (@(posedge clk) disable iff (!rstN) err |=> err)
      else $error("err dropped without reset");

   pcEven: assert property (@(posedge clk) disable iff (!rstN) !instrAddr[0])
      else $error("instrAddr is odd");

endmodule

bind proc procAssert iAssert (
   .clk(clk), .rstN(rstN), .memWe(memWe), .memRe(memRe),
   .halted(halted), .err(err), .instrAddr(instrAddr)
);

/* verif/procTb.sv */
module procTb;
   timeunit 1ns;
   timeprecision 100ps;

   import isaPkg::*;

   localparam wordT        ResetPc     = 16'h0000;
   localparam int          ClkHalf     = 10;          // 20 ns period
   localparam int          ResetCycles = 10;
   localparam int          StopTimeout = 2000;        // Cycles per program
   localparam int          MemWords    = 256;
   localparam int          RandomPairs = 20;
   localparam logic [31:0] LfsrSeed    = 32'h6481;
   localparam logic [31:0] LfsrTaps    = 32'h80200003;

   logic clk;
   logic rstN;
   wordT instr;
   wordT memRdata;
   wordT instrAddr;
   wordT memAddr;
   wordT memWdata;
   logic memWe;
   logic memRe;
   logic halted;
   logic err;

   wordT        imem [MemWords];                      // Word per instruction slot
   wordT        dmem [MemWords];                      // Word addressed
   wordT        expAddr [$];
   wordT        expData [$];
   wordT        gotAddr [$];                          // Store log from the bus
   wordT        gotData [$];
   wordT        expLoads [$];
   wordT        gotLoads [$];                         // Load address log
   int          progLen;
   int          errors;
   int          checks;
   int          busErrors = 0;
   logic [31:0] lfsrState;
   logic        prevWe;
   logic        prevRe;
   logic        prevHalted;
   logic        prevErr;

   proc #(.ResetPc(ResetPc)) u_proc (
      .clk(clk), .rstN(rstN), .instr(instr), .memRdata(memRdata),
      .instrAddr(instrAddr), .memAddr(memAddr), .memWdata(memWdata),
      .memWe(memWe), .memRe(memRe), .halted(halted), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #ClkHalf clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Memory models
   ////////////////////////////////////////////////////////////////////////////
   assign instr    = imem[instrAddr[8:1]];            // Byte address to word slot
   assign memRdata = rstN ? dmem[memAddr[7:0]] : '0;

   always @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < MemWords; i++) begin
            dmem[i] <= dataFill(i);                   // Fresh pattern every reset
         end
         gotAddr.delete();
         gotData.delete();
         gotLoads.delete();
      end else begin
         if (memWe) begin
            dmem[memAddr[7:0]] <= memWdata;
            gotAddr.push_back(memAddr);
            gotData.push_back(memWdata);
         end
         if (memRe) begin
            gotLoads.push_back(memAddr);
         end
      end
   end

   // Bus rules, sampled before the edge updates
   always @(posedge clk) begin
      if (!rstN) begin
         prevWe     <= 1'b0;
         prevRe     <= 1'b0;
         prevHalted <= 1'b0;
         prevErr    <= 1'b0;
      end else begin
         if (memWe && memRe) begin
            $display("ERROR: memWe and memRe high in the same cycle at %0t", $time);
            busErrors++;
         end
         if ((memWe && prevWe) || (memRe && prevRe)) begin
            $display("ERROR: memory strobe held longer than one cycle at %0t", $time);
            busErrors++;
         end
         if ((prevHalted && !halted) || (prevErr && !err)) begin
            $display("ERROR: halted or err dropped without reset at %0t", $time);
            busErrors++;
         end
         if (instrAddr[0]) begin
            $display("ERROR: odd instruction address %h at %0t", instrAddr, $time);
            busErrors++;
         end
         prevWe     <= memWe;
         prevRe     <= memRe;
         prevHalted <= halted;
         prevErr    <= err;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // ISA rules and instruction encoders
   ////////////////////////////////////////////////////////////////////////////
   function automatic wordT sext5(input int v);
      return {{11{v[4]}}, v[4:0]};
   endfunction

   function automatic wordT sext8(input int v);
      return {{8{v[7]}}, v[7:0]};
   endfunction

   function automatic wordT aluRef(input int fn, input wordT rsV, input wordT rtV);
      case (fn)
         0:       return rsV + rtV;                   // ADD
         1:       return rtV - rsV;                   // SUB is Rt minus Rs
         2:       return rsV ^ rtV;
         default: return rsV & rtV;
      endcase
   endfunction

   function automatic wordT dataFill(input int i);
      return {8'hD5, i[7:0]};
   endfunction

   function automatic wordT lbiWord(input int rs, input int imm8);
      return {OpLbi, rs[2:0], imm8[7:0]};
   endfunction

   function automatic wordT immWord(input opcodeE op, input int rs, input int rt, input int imm5);
      return {op, rs[2:0], rt[2:0], imm5[4:0]};
   endfunction

   function automatic wordT aluWord(input int rs, input int rt, input int rd, input int fn);
      return {OpAlu, rs[2:0], rt[2:0], rd[2:0], fn[1:0]};
   endfunction

   function automatic wordT branchWord(input opcodeE op, input int rs, input int imm8);
      return {op, rs[2:0], imm8[7:0]};
   endfunction

   function automatic wordT jumpWord(input int disp11);
      return {OpJ, disp11[10:0]};
   endfunction

   function automatic wordT haltWord();
      return {OpHalt, 11'd0};
   endfunction

   // Galois LFSR, one step per bit
   function automatic int randByte();
      int v;
      v = 0;
      for (int i = 0; i < 8; i++) begin
         lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ LfsrTaps) : (lfsrState >> 1);
         v = (v << 1) | int'(lfsrState[0]);
      end
      return v;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Shared tasks
   ////////////////////////////////////////////////////////////////////////////
   task automatic checkEq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic initMemories();
      for (int i = 0; i < MemWords; i++) begin
         imem[i] = {OpHalt, 3'b000, 8'(i)};           // HALT tagged with its slot
      end
      progLen = 0;
      expAddr.delete();
      expData.delete();
      expLoads.delete();
   endtask

   task automatic emit(input wordT w);
      imem[progLen[7:0]] = w;
      progLen++;
   endtask

   task automatic expectStore(input wordT addr, input wordT data);
      expAddr.push_back(addr);
      expData.push_back(data);
   endtask

   task automatic expectLoad(input wordT addr);
      expLoads.push_back(addr);
   endtask

   task automatic pulseReset();
      @(negedge clk);
      rstN = 1'b0;
      repeat (ResetCycles) @(negedge clk);
      rstN = 1'b1;
   endtask

   // Runs until halted or err, counting rising edges
   task automatic awaitStop(input string name, input logic expectHalt, output int cycles);
      cycles = 0;
      while (!(halted || err) && (cycles < StopTimeout)) begin
         @(negedge clk);
         cycles++;
      end
      if (!(halted || err)) begin
         $display("ERROR: %s reached neither halted nor err in %0d cycles", name, StopTimeout);
         errors++;
      end
      checkEq({name, " halted"}, 32'(expectHalt), 32'(halted));
      checkEq({name, " err"}, 32'(!expectHalt), 32'(err));
   endtask

   task automatic compareStores(input string name);
      int n;
      checkEq({name, " store count"}, expAddr.size(), gotAddr.size());
      n = (expAddr.size() < gotAddr.size()) ? expAddr.size() : gotAddr.size();
      for (int i = 0; i < n; i++) begin
         checkEq($sformatf("%s store %0d addr", name, i), 32'(expAddr[i]), 32'(gotAddr[i]));
         checkEq($sformatf("%s store %0d data", name, i), 32'(expData[i]), 32'(gotData[i]));
      end
   endtask

   task automatic compareLoads(input string name);
      int n;
      checkEq({name, " load count"}, expLoads.size(), gotLoads.size());
      n = (expLoads.size() < gotLoads.size()) ? expLoads.size() : gotLoads.size();
      for (int i = 0; i < n; i++) begin
         checkEq($sformatf("%s load %0d addr", name, i), 32'(expLoads[i]), 32'(gotLoads[i]));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////
   task automatic resetHaltTest();
      int cycles;
      initMemories();
      emit(haltWord());
      pulseReset();
      checkEq("resetHalt pc", 32'(ResetPc), 32'(instrAddr));
      checkEq("resetHalt strobes", 0, 32'({memWe, memRe, halted, err}));
      awaitStop("resetHalt", 1'b1, cycles);
      checkEq("resetHalt cycles", 2, cycles);         // Fetch and Decode only
      compareStores("resetHalt");
      compareLoads("resetHalt");
   endtask

   task automatic arithTest();
      int   cycles;
      wordT a;
      wordT b;
      initMemories();
      a = sext8('h35);
      b = sext8('hF9);
      emit(lbiWord(1, 'h35));
      emit(lbiWord(2, 'hF9));
      emit(immWord(OpAddi, 1, 3, 'h1D));              // r3 = r1 - 3
      emit(immWord(OpSt, 0, 3, 0));
      expectStore(16'd0, a + sext5('h1D));
      emit(immWord(OpSubi, 1, 4, 'h0A));              // r4 = 10 - r1
      emit(immWord(OpSt, 0, 4, 1));
      expectStore(16'd1, sext5('h0A) - a);
      for (int f = 0; f < 4; f++) begin
         emit(aluWord(1, 2, 5, f));
         emit(immWord(OpSt, 0, 5, 2 + f));
         expectStore(16'(2 + f), aluRef(f, a, b));
      end
      emit(immWord(OpSt, 0, 1, 6));                   // LBI values themselves
      expectStore(16'd6, a);
      emit(immWord(OpSt, 0, 2, 7));
      expectStore(16'd7, b);
      emit(haltWord());
      pulseReset();
      awaitStop("arith", 1'b1, cycles);
      checkEq("arith cycles", 5 * (progLen - 1) + 2, cycles);
      compareStores("arith");
      compareLoads("arith");
   endtask

   task automatic loadUseTest();
      int   cycles;
      wordT v;
      initMemories();
      v = sext8('h5A) + sext5(7);
      emit(lbiWord(1, 'h5A));
      emit(lbiWord(2, 20));                           // Base address
      emit(immWord(OpSt, 2, 1, 3));                   // mem[23] = r1
      emit(immWord(OpLd, 2, 3, 3));                   // r3 = mem[23]
      emit(immWord(OpAddi, 3, 3, 7));
      emit(immWord(OpSt, 2, 3, 4));                   // mem[24] = r3
      emit(immWord(OpLd, 0, 4, 9));                   // Untouched word
      emit(immWord(OpSt, 2, 4, 5));
      emit(haltWord());
      expectStore(16'd23, sext8('h5A));
      expectStore(16'd24, v);
      expectStore(16'd25, dataFill(9));
      expectLoad(16'd23);
      expectLoad(16'd9);
      pulseReset();
      awaitStop("loadUse", 1'b1, cycles);
      checkEq("loadUse cycles", 5 * (progLen - 1) + 2, cycles);
      compareStores("loadUse");
      compareLoads("loadUse");
      checkEq("loadUse final word", 32'(v), 32'(dmem[24]));
   endtask

   task automatic controlFlowTest();
      int cycles;
      initMemories();
      emit(lbiWord(1, 0));                            // 0  r1 = 0
      emit(lbiWord(2, 1));                            // 1  r2 = 1
      emit(branchWord(OpBeqz, 1, 2));                 // 2  Taken to 4
      emit(immWord(OpSt, 0, 2, 1));                   // 3  Skipped
      emit(immWord(OpSt, 0, 2, 2));                   // 4
      emit(branchWord(OpBeqz, 2, 2));                 // 5  Not taken
      emit(immWord(OpSt, 0, 2, 3));                   // 6
      emit(branchWord(OpBnez, 2, 2));                 // 7  Taken to 9
      emit(immWord(OpSt, 0, 2, 4));                   // 8  Skipped
      emit(branchWord(OpBnez, 1, 2));                 // 9  Not taken
      emit(immWord(OpSt, 0, 2, 5));                   // 10
      emit(jumpWord(4));                              // 11 Lands on 14
      emit(immWord(OpSt, 0, 2, 6));                   // 12 Skipped
      emit(immWord(OpSt, 0, 2, 7));                   // 13 Skipped
      emit(immWord(OpSt, 0, 2, 8));                   // 14
      emit(haltWord());
      expectStore(16'd2, 16'd1);
      expectStore(16'd3, 16'd1);
      expectStore(16'd5, 16'd1);
      expectStore(16'd8, 16'd1);
      pulseReset();
      awaitStop("controlFlow", 1'b1, cycles);
      checkEq("controlFlow cycles", 5 * 11 + 2, cycles); // Eleven on the path
      compareStores("controlFlow");
      compareLoads("controlFlow");
   endtask

   task automatic illegalOpTest();
      int cycles;
      initMemories();
      emit(lbiWord(1, 3));
      emit(immWord(OpSt, 0, 1, 0));
      emit(16'hF800);                                 // Opcode 11111
      emit(immWord(OpSt, 0, 1, 1));                   // Must never run
      emit(haltWord());
      expectStore(16'd0, 16'd3);
      pulseReset();
      awaitStop("illegalOp", 1'b0, cycles);
      checkEq("illegalOp cycles", 5 * 2 + 2, cycles);
      compareStores("illegalOp");
      compareLoads("illegalOp");
   endtask

   task automatic randomOpsTest();
      int   cycles;
      int   ra;
      int   rb;
      wordT a;
      wordT b;
      initMemories();
      for (int k = 0; k < RandomPairs; k++) begin
         ra = randByte();
         rb = randByte();
         a  = sext8(ra);
         b  = sext8(rb);
         emit(lbiWord(1, ra));
         emit(lbiWord(2, rb));
         for (int f = 0; f < 4; f++) begin
            emit(aluWord(1, 2, 3, f));
            emit(immWord(OpSt, 0, 3, f));
            expectStore(16'(f), aluRef(f, a, b));
         end
      end
      emit(haltWord());
      pulseReset();
      awaitStop("randomOps", 1'b1, cycles);
      checkEq("randomOps cycles", 5 * (progLen - 1) + 2, cycles);
      compareStores("randomOps");
      compareLoads("randomOps");
   endtask

   initial begin
      rstN      = 1'b0;
      lfsrState = LfsrSeed;
      errors    = 0;
      checks    = 0;
      initMemories();
      resetHaltTest();
      arithTest();
      loadUseTest();
      controlFlowTest();
      illegalOpTest();
      randomOpsTest();
      $display("Summary: %0d checks, %0d check errors, %0d bus errors",
               checks, errors, busErrors);
      if ((errors + busErrors) == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

/* tb.f */
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/stageSequencer.sv
logic/pcCounter.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/execUnit.sv
logic/proc.sv
verif/proc_assert.sv
verif/procTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
TOP       ?= procTb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIMFLAGS  ?= +verilator+error+limit+100
FAIL_MSG  := Something failed
PASS_MSG  := Everything OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
